/* bench/tb_tasks.svh */
task automatic compare_ctrl(input string name, input ctrl_pkg::ctrl_word_t exp,
                            input ctrl_pkg::ctrl_word_t act);
    if (act !== exp) begin
        $display("Error %s: ctrl expected %h actual %h", name, exp, act);
        err_count++;
    end
endtask

task automatic compare_data(input string name, input logic [`APB_DATA_W-1:0] exp,
                            input logic [`APB_DATA_W-1:0] act);
    if (act !== exp) begin
        $display("Error %s: data expected %h actual %h", name, exp, act);
        err_count++;
    end
endtask

task automatic compare_mode(input string name, input ctrl_pkg::panel_mode_t exp,
                            input ctrl_pkg::panel_mode_t act);
    if (act !== exp) begin
        $display("Error %s: mode expected %b actual %b", name, exp, act);
        err_count++;
    end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Error %s: pslverr expected %b actual %b", name, exp, act);
        err_count++;
    end
endtask

task automatic start_test();
    errs_at_start = err_count;
    tests_run++;
endtask

task automatic finish_test(input string name);
    if (err_count == errs_at_start) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, err_count - errs_at_start);
        tests_failed++;
    end
endtask

// fetch/execute word from the opcode tables
function automatic ctrl_pkg::ctrl_word_t exec_ref(input logic st0, input ctrl_pkg::beat_t beat,
                                                  input ctrl_pkg::opcode_t op,
                                                  input logic cf, input logic zf);
    ctrl_pkg::ctrl_word_t w;
    w = '0;
    if (!st0) begin
        w.stop = (beat == ctrl_pkg::BEAT_W1);
        w.sbus = (beat == ctrl_pkg::BEAT_W2);
        w.lpc  = (beat == ctrl_pkg::BEAT_W2);
    end else if (beat == ctrl_pkg::BEAT_W1) begin
        w.lir   = 1'b1;
        w.pcinc = 1'b1;
    end else if (beat == ctrl_pkg::BEAT_W2) begin
        case (op)
            ctrl_pkg::OP_ADD, ctrl_pkg::OP_SUB, ctrl_pkg::OP_AND, ctrl_pkg::OP_INC: begin
                w.abus = 1'b1;
                w.drw  = 1'b1;
                w.ldz  = 1'b1;
                w.ldc  = (op != ctrl_pkg::OP_AND);
                w.m    = (op == ctrl_pkg::OP_AND);
                w.cin  = (op == ctrl_pkg::OP_ADD);
                w.s    = (op == ctrl_pkg::OP_ADD) ? 4'b1001 :
                         (op == ctrl_pkg::OP_SUB) ? 4'b0110 :
                         (op == ctrl_pkg::OP_AND) ? 4'b1011 : 4'b0000;
            end
            ctrl_pkg::OP_LD, ctrl_pkg::OP_ST: begin
                w.m        = 1'b1;
                w.abus     = 1'b1;
                w.lar      = 1'b1;
                w.long_cyc = 1'b1;
                w.s        = (op == ctrl_pkg::OP_LD) ? 4'b1010 : 4'b1111;
            end
            ctrl_pkg::OP_JC:  w.pcadd = cf;
            ctrl_pkg::OP_JZ:  w.pcadd = zf;
            ctrl_pkg::OP_JMP: begin
                w.m    = 1'b1;
                w.s    = 4'b1111;
                w.abus = 1'b1;
                w.lpc  = 1'b1;
            end
            ctrl_pkg::OP_STP: w.stop = 1'b1;
            default:          w = '0;
        endcase
    end else if (beat == ctrl_pkg::BEAT_W3 && op == ctrl_pkg::OP_LD) begin
        w.drw  = 1'b1;
        w.mbus = 1'b1;
    end else if (beat == ctrl_pkg::BEAT_W3 && op == ctrl_pkg::OP_ST) begin
        w.m    = 1'b1;
        w.s    = 4'b1010;
        w.abus = 1'b1;
        w.memw = 1'b1;
    end
    return w;
endfunction

function automatic ctrl_pkg::ctrl_word_t expected_word(input ctrl_pkg::panel_mode_t md,
                                                       input logic st0,
                                                       input ctrl_pkg::beat_t beat,
                                                       input ctrl_pkg::opcode_t op,
                                                       input logic cf, input logic zf);
    ctrl_pkg::ctrl_word_t w;
    logic                 w1;
    logic                 w2;
    w  = '0;
    w1 = (beat == ctrl_pkg::BEAT_W1);
    w2 = (beat == ctrl_pkg::BEAT_W2);
    case (md)
        ctrl_pkg::MODE_FETCH: w = exec_ref(st0, beat, op, cf, zf);
        ctrl_pkg::MODE_WR_REG: begin
            w.sbus    = w1 | w2;
            w.sel_ctl = w1 | w2;
            w.drw     = w1 | w2;
            w.stop    = w1 | w2;
            if (w1) begin
                w.sel = st0 ? 4'b1001 : 4'b0011;
            end else if (w2) begin
                w.sel = st0 ? 4'b1110 : 4'b0100;
            end
        end
        ctrl_pkg::MODE_RD_REG: begin
            w.sel_ctl = w1 | w2;
            w.stop    = w1 | w2;
            w.sel     = w1 ? 4'b0001 : (w2 ? 4'b1011 : 4'b0000);
        end
        ctrl_pkg::MODE_RD_MEM, ctrl_pkg::MODE_WR_MEM: begin
            w.stop      = w1;
            w.short_cyc = w1;
            w.sel_ctl   = w1;
            w.lar       = w1 & ~st0;   // address phase
            w.arinc     = w1 & st0;
            w.sbus      = w1 & (~st0 | (md == ctrl_pkg::MODE_WR_MEM));
            w.mbus      = w1 & st0 & (md == ctrl_pkg::MODE_RD_MEM);
            w.memw      = w1 & st0 & (md == ctrl_pkg::MODE_WR_MEM);
        end
        default: w = '0;
    endcase
    return w;
endfunction

task automatic model_restart();
    m_beat = ctrl_pkg::BEAT_W1;
    m_st0  = 1'b0;
    m_long = 1'b0;
endtask

task automatic model_step(input ctrl_pkg::panel_mode_t md, input ctrl_pkg::opcode_t op);
    logic set_st0;
    logic clr_st0;
    set_st0 = !m_st0 &&
              ((md == ctrl_pkg::MODE_WR_REG && m_beat == ctrl_pkg::BEAT_W2) ||
               (md == ctrl_pkg::MODE_RD_MEM && m_beat == ctrl_pkg::BEAT_W1) ||
               (md == ctrl_pkg::MODE_WR_MEM && m_beat == ctrl_pkg::BEAT_W1) ||
               (md == ctrl_pkg::MODE_FETCH  && m_beat == ctrl_pkg::BEAT_W2));
    clr_st0 = m_st0 && md == ctrl_pkg::MODE_WR_REG && m_beat == ctrl_pkg::BEAT_W2;
    case (m_beat)
        ctrl_pkg::BEAT_W1: begin
            m_long = (op == ctrl_pkg::OP_LD) || (op == ctrl_pkg::OP_ST);
            m_beat = ctrl_pkg::BEAT_W2;
        end
        ctrl_pkg::BEAT_W2: m_beat = m_long ? ctrl_pkg::BEAT_W3 : ctrl_pkg::BEAT_W1;
        default:           m_beat = ctrl_pkg::BEAT_W1;
    endcase
    if (set_st0) begin
        m_st0 = 1'b1;
    end else if (clr_st0) begin
        m_st0 = 1'b0;
    end
endtask

// one APB transfer that starts and ends on a falling edge
task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                        input logic [`APB_DATA_W-1:0] wdata,
                        output logic [`APB_DATA_W-1:0] rdata, output logic err);
    int waited;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge t3);
    apb_req.penable = 1'b1;
    #1;
    waited = 0;
    while (!apb_rsp.pready && waited < APB_TIMEOUT) begin
        @(negedge t3);
        #1;
        waited++;
    end
    if (!apb_rsp.pready) begin
        abort_run("APB slave never raised pready");
    end else begin
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge t3);
        apb_req = '0;
    end
endtask

task automatic write_mode(input string name, input ctrl_pkg::panel_mode_t md);
    logic [`APB_DATA_W-1:0] rdata;
    logic                   err;
    apb_xfer(1'b1, `REG_MODE_OFS, `APB_DATA_W'(md), rdata, err);
    compare_flag(name, 1'b0, err);
    cur_mode = md;
    model_restart();   // restart puts the sequencer at W1 with st0 0
endtask

task automatic check_beat(input string name, input ctrl_pkg::opcode_t op,
                          input logic cf, input logic zf);
    ctrl_pkg::ctrl_word_t exp;
    ir = op;
    c  = cf;
    z  = zf;
    #2;
    exp = expected_word(cur_mode, m_st0, m_beat, op, cf, zf);
    compare_ctrl(name, exp, ctrl);
    @(negedge t3);
    model_step(cur_mode, op);
endtask

task automatic test_reset_regs();
    logic [`APB_DATA_W-1:0] rdata;
    logic                   err;
    start_test();
    #2;
    compare_ctrl("reset_regs", '0, ctrl);
    compare_data("reset_regs", '0, apb_rsp.prdata);
    compare_flag("reset_regs", 1'b0, apb_rsp.pslverr);
    @(negedge t3);
    apb_xfer(1'b0, `REG_MODE_OFS, '0, rdata, err);
    compare_mode("reset_regs", ctrl_pkg::MODE_IDLE, ctrl_pkg::panel_mode_t'(rdata[2:0]));
    compare_flag("reset_regs", 1'b0, err);
    write_mode("reset_regs", ctrl_pkg::MODE_RD_REG);
    apb_xfer(1'b0, `REG_STATUS_OFS, '0, rdata, err);
    compare_data("reset_regs", `APB_DATA_W'({m_beat, m_st0}), rdata);
    compare_flag("reset_regs", 1'b0, err);
    apb_xfer(1'b0, `REG_MODE_OFS, '0, rdata, err);
    compare_mode("reset_regs", ctrl_pkg::MODE_RD_REG, ctrl_pkg::panel_mode_t'(rdata[2:0]));
    apb_xfer(1'b0, 8'h08, '0, rdata, err);   // unmapped offset
    compare_flag("reset_regs", 1'b1, err);
    apb_xfer(1'b1, `REG_STATUS_OFS, 32'h5, rdata, err);
    compare_flag("reset_regs", 1'b1, err);
    finish_test("reset_regs");
endtask

task automatic test_wr_reg();
    start_test();
    write_mode("wr_reg", ctrl_pkg::MODE_WR_REG);
    repeat (8) check_beat("wr_reg", ctrl_pkg::OP_ADD, 1'b0, 1'b0);
    finish_test("wr_reg");
endtask

task automatic test_rd_modes();
    start_test();
    write_mode("rd_modes", ctrl_pkg::MODE_RD_REG);
    repeat (4) check_beat("rd_modes", ctrl_pkg::OP_ADD, 1'b0, 1'b0);
    write_mode("rd_modes", ctrl_pkg::MODE_RD_MEM);
    repeat (5) check_beat("rd_modes", ctrl_pkg::OP_ADD, 1'b0, 1'b0);
    write_mode("rd_modes", ctrl_pkg::MODE_WR_MEM);
    repeat (5) check_beat("rd_modes", ctrl_pkg::OP_ADD, 1'b0, 1'b0);
    finish_test("rd_modes");
endtask

task automatic test_fetch_base();
    ctrl_pkg::opcode_t ops[6];
    start_test();
    ops = '{ctrl_pkg::OP_ADD, ctrl_pkg::OP_SUB, ctrl_pkg::OP_AND,
            ctrl_pkg::OP_INC, ctrl_pkg::OP_JMP, ctrl_pkg::OP_STP};
    foreach (ops[i]) begin
        write_mode("fetch_base", ctrl_pkg::MODE_FETCH);
        repeat (4) check_beat("fetch_base", ops[i], 1'b0, 1'b0);
    end
    finish_test("fetch_base");
endtask

task automatic test_flags_long();
    logic [3:0] spare[6];
    logic       cf;
    logic       zf;
    start_test();
    spare = '{4'b0000, 4'b1010, 4'b1011, 4'b1100, 4'b1101, 4'b1111};  // unlisted codes
    for (int i = 0; i < 8; i++) begin
        cf = 1'($urandom);
        zf = 1'($urandom);
        write_mode("flags_long", ctrl_pkg::MODE_FETCH);
        repeat (4) begin
            check_beat("flags_long", (i % 2 == 0) ? ctrl_pkg::OP_JC : ctrl_pkg::OP_JZ, cf, zf);
        end
    end
    write_mode("flags_long", ctrl_pkg::MODE_FETCH);
    repeat (8) check_beat("flags_long", ctrl_pkg::OP_LD, 1'b0, 1'b0);
    write_mode("flags_long", ctrl_pkg::MODE_FETCH);
    repeat (8) check_beat("flags_long", ctrl_pkg::OP_ST, 1'b0, 1'b0);
    foreach (spare[i]) begin
        write_mode("flags_long", ctrl_pkg::MODE_FETCH);
        repeat (4) check_beat("flags_long", ctrl_pkg::opcode_t'(spare[i]), 1'b1, 1'b1);
    end
    finish_test("flags_long");
endtask

/* bench/tb_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module tb_control_unit;

    localparam int APB_TIMEOUT = 16;   // cycles to wait for pready

    logic                  t3;
    logic                  rst_n;
    ctrl_pkg::apb_req_t    apb_req;
    ctrl_pkg::apb_rsp_t    apb_rsp;
    ctrl_pkg::opcode_t     ir;
    logic                  c;
    logic                  z;
    ctrl_pkg::ctrl_word_t  ctrl;

    // reference model of the beat sequencer
    ctrl_pkg::panel_mode_t cur_mode;
    ctrl_pkg::beat_t       m_beat;
    logic                  m_st0;
    logic                  m_long;

    int err_count;
    int errs_at_start;
    int tests_run;
    int tests_failed;

    control_unit_top dut (
        .t3      (t3),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .ir      (ir),
        .c       (c),
        .z       (z),
        .ctrl    (ctrl)
    );

    initial begin
        t3 = 1'b0;
        forever #4 t3 = ~t3;   // 8 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    `include "tb_tasks.svh"

    initial begin
        rst_n        = 1'b0;
        apb_req      = '0;
        ir           = ctrl_pkg::OP_ADD;
        c            = 1'b0;
        z            = 1'b0;
        cur_mode     = ctrl_pkg::MODE_IDLE;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_restart();
        void'($urandom(39197));
        repeat (10) @(posedge t3);
        @(negedge t3);
        rst_n = 1'b1;

        test_reset_regs();
        test_wr_reg();
        test_rd_modes();
        test_fetch_base();
        test_flags_long();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
+incdir+bench
design/ctrl_pkg.sv
design/panel_regs.sv
design/beat_sequencer.sv
design/instr_decoder.sv
design/mode_decoder.sv
design/control_unit_top.sv
bench/tb_control_unit.sv

/* design/beat_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_sequencer (
    input  wire                    t3,
    input  wire                    rst_n,
    input  logic                   restart,
    input  ctrl_pkg::panel_mode_t  mode,
    input  ctrl_pkg::opcode_t      ir,
    output ctrl_pkg::seq_status_t  status
);

    ctrl_pkg::beat_t beat_q;
    logic            long_q;    // LD/ST needs a W3 beat
    logic            st0_q;
    logic            is_w1;
    logic            is_w2;
    logic            set_st0;
    logic            clr_st0;

    assign is_w1 = (beat_q == ctrl_pkg::BEAT_W1);
    assign is_w2 = (beat_q == ctrl_pkg::BEAT_W2);

    assign set_st0 = ~st0_q & (
        ((mode == ctrl_pkg::MODE_WR_REG) & is_w2) |
        ((mode == ctrl_pkg::MODE_RD_MEM) & is_w1) |
        ((mode == ctrl_pkg::MODE_WR_MEM) & is_w1) |
        ((mode == ctrl_pkg::MODE_FETCH)  & is_w2));

    // write register alternates between the two register pairs
    assign clr_st0 = st0_q & is_w2 & (mode == ctrl_pkg::MODE_WR_REG);

    always_ff @(posedge t3) begin
        if (!rst_n || restart) begin
            beat_q <= ctrl_pkg::BEAT_W1;
            long_q <= 1'b0;
            st0_q  <= 1'b0;
        end else begin
            case (beat_q)
                ctrl_pkg::BEAT_W1: begin
                    beat_q <= ctrl_pkg::BEAT_W2;
                    long_q <= (ir == ctrl_pkg::OP_LD) || (ir == ctrl_pkg::OP_ST);
                end
                ctrl_pkg::BEAT_W2: beat_q <= long_q ? ctrl_pkg::BEAT_W3 : ctrl_pkg::BEAT_W1;
                default:           beat_q <= ctrl_pkg::BEAT_W1;  // W3 and stray codes
            endcase
            if (set_st0) begin
                st0_q <= 1'b1;
            end else if (clr_st0) begin
                st0_q <= 1'b0;
            end
        end
    end

    assign status = '{beat: beat_q, st0: st0_q};

endmodule

`default_nettype wire

/* design/control_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_top (
    input  wire                   t3,
    input  wire                   rst_n,
    input  ctrl_pkg::apb_req_t    apb_req,
    output ctrl_pkg::apb_rsp_t    apb_rsp,
    input  ctrl_pkg::opcode_t     ir,
    input  wire                   c,
    input  wire                   z,
    output ctrl_pkg::ctrl_word_t  ctrl
);

    ctrl_pkg::panel_mode_t mode;
    ctrl_pkg::seq_status_t status;
    ctrl_pkg::ctrl_word_t  exec_word;
    logic                  restart;

    panel_regs u_panel_regs (
        .t3      (t3),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .status  (status),
        .mode    (mode),
        .restart (restart)
    );

    beat_sequencer u_beat_sequencer (
        .t3      (t3),
        .rst_n   (rst_n),
        .restart (restart),
        .mode    (mode),
        .ir      (ir),
        .status  (status)
    );

    // fetch/execute word for fetch mode only
    instr_decoder u_instr_decoder (
        .status (status),
        .ir     (ir),
        .c      (c),
        .z      (z),
        .word   (exec_word)
    );

    mode_decoder u_mode_decoder (
        .mode      (mode),
        .status    (status),
        .exec_word (exec_word),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

/* design/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// field widths
`define CTRL_MODE_W 3
`define CTRL_OP_W 4
`define CTRL_FN_W 4
`define CTRL_SEL_W 4

// APB bus
`define APB_ADDR_W 8
`define APB_DATA_W 32

// register map
`define REG_MODE_OFS 8'h00
`define REG_STATUS_OFS 8'h04

// panel comes up idle
`define MODE_RESET_CODE 3'b111

`endif

/* design/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_defs.svh"

package ctrl_pkg;

    typedef enum logic [`CTRL_MODE_W-1:0] {
        MODE_FETCH  = 3'b000,   // fetch/execute
        MODE_WR_MEM = 3'b001,
        MODE_RD_MEM = 3'b010,
        MODE_RD_REG = 3'b011,
        MODE_WR_REG = 3'b100,
        MODE_IDLE   = 3'b111
    } panel_mode_t;

    typedef enum logic [`CTRL_OP_W-1:0] {
        OP_ADD = 4'b0001,
        OP_SUB = 4'b0010,
        OP_AND = 4'b0011,
        OP_INC = 4'b0100,
        OP_LD  = 4'b0101,
        OP_ST  = 4'b0110,
        OP_JC  = 4'b0111,
        OP_JZ  = 4'b1000,
        OP_JMP = 4'b1001,
        OP_STP = 4'b1110
    } opcode_t;

    typedef enum logic [1:0] {
        BEAT_W1 = 2'd0,
        BEAT_W2 = 2'd1,
        BEAT_W3 = 2'd2          // only after LD/ST
    } beat_t;

    typedef logic [`CTRL_FN_W-1:0]  alu_fn_t;   // ALU function S
    typedef logic [`CTRL_SEL_W-1:0] reg_sel_t;  // register select SEL

    typedef struct packed {
        logic     sel_ctl;
        logic     abus;
        logic     sbus;
        logic     mbus;
        logic     m;
        logic     cin;
        logic     drw;
        logic     ldz;
        logic     ldc;
        logic     memw;
        logic     arinc;
        logic     pcinc;
        logic     pcadd;
        logic     lpc;
        logic     lar;
        logic     lir;
        logic     stop;
        logic     short_cyc;
        logic     long_cyc;
        alu_fn_t  s;
        reg_sel_t sel;
    } ctrl_word_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // packs as {beat, st0} like the STATUS register
    typedef struct packed {
        beat_t beat;
        logic  st0;
    } seq_status_t;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  ctrl_pkg::seq_status_t status,
    input  ctrl_pkg::opcode_t     ir,
    input  logic                  c,
    input  logic                  z,
    output ctrl_pkg::ctrl_word_t  word
);

    always_comb begin
        word = '0;
        if (!status.st0) begin
            // first pass after restart loads PC from the switches
            case (status.beat)
                ctrl_pkg::BEAT_W1: word.stop = 1'b1;
                ctrl_pkg::BEAT_W2: begin
                    word.sbus = 1'b1;
                    word.lpc  = 1'b1;
                end
                default: word = '0;
            endcase
        end else begin
            case (status.beat)
                ctrl_pkg::BEAT_W1: begin
                    word.lir   = 1'b1;   // fetch
                    word.pcinc = 1'b1;
                end
                ctrl_pkg::BEAT_W2: begin
                    case (ir)
                        ctrl_pkg::OP_ADD: begin
                            word.s    = 4'b1001;
                            word.cin  = 1'b1;
                            word.abus = 1'b1;
                            word.drw  = 1'b1;
                            word.ldz  = 1'b1;
                            word.ldc  = 1'b1;
                        end
                        ctrl_pkg::OP_SUB: begin
                            word.s    = 4'b0110;
                            word.abus = 1'b1;
                            word.drw  = 1'b1;
                            word.ldz  = 1'b1;
                            word.ldc  = 1'b1;
                        end
                        ctrl_pkg::OP_AND: begin
                            word.m    = 1'b1;    // logic op leaves carry alone
                            word.s    = 4'b1011;
                            word.abus = 1'b1;
                            word.drw  = 1'b1;
                            word.ldz  = 1'b1;
                        end
                        ctrl_pkg::OP_INC: begin
                            word.s    = 4'b0000;
                            word.abus = 1'b1;
                            word.drw  = 1'b1;
                            word.ldz  = 1'b1;
                            word.ldc  = 1'b1;
                        end
                        ctrl_pkg::OP_LD: begin
                            word.m        = 1'b1;
                            word.s        = 4'b1010;
                            word.abus     = 1'b1;
                            word.lar      = 1'b1;  // address to AR
                            word.long_cyc = 1'b1;
                        end
                        ctrl_pkg::OP_ST: begin
                            word.m        = 1'b1;
                            word.s        = 4'b1111;
                            word.abus     = 1'b1;
                            word.lar      = 1'b1;
                            word.long_cyc = 1'b1;
                        end
                        ctrl_pkg::OP_JC:  word.pcadd = c;
                        ctrl_pkg::OP_JZ:  word.pcadd = z;
                        ctrl_pkg::OP_JMP: begin
                            word.m    = 1'b1;
                            word.s    = 4'b1111;
                            word.abus = 1'b1;
                            word.lpc  = 1'b1;
                        end
                        ctrl_pkg::OP_STP: word.stop = 1'b1;
                        default:          word = '0;  // extension opcodes dropped
                    endcase
                end
                ctrl_pkg::BEAT_W3: begin
                    case (ir)
                        ctrl_pkg::OP_LD: begin
                            word.drw  = 1'b1;    // memory data into register
                            word.mbus = 1'b1;
                        end
                        ctrl_pkg::OP_ST: begin
                            word.m    = 1'b1;
                            word.s    = 4'b1010;
                            word.abus = 1'b1;
                            word.memw = 1'b1;
                        end
                        default: word = '0;
                    endcase
                end
                default: word = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/mode_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_decoder (
    input  ctrl_pkg::panel_mode_t mode,
    input  ctrl_pkg::seq_status_t status,
    input  ctrl_pkg::ctrl_word_t  exec_word,
    output ctrl_pkg::ctrl_word_t  ctrl
);

    logic is_w1;
    logic is_w2;

    assign is_w1 = (status.beat == ctrl_pkg::BEAT_W1);
    assign is_w2 = (status.beat == ctrl_pkg::BEAT_W2);

    always_comb begin
        ctrl = '0;
        case (mode)
            ctrl_pkg::MODE_FETCH: ctrl = exec_word;
            ctrl_pkg::MODE_WR_REG: begin
                if (is_w1 || is_w2) begin
                    ctrl.sbus    = 1'b1;
                    ctrl.sel_ctl = 1'b1;
                    ctrl.drw     = 1'b1;
                    ctrl.stop    = 1'b1;
                    // st0 picks the register pair, beat picks the register
                    case ({status.st0, is_w2})
                        2'b00:   ctrl.sel = 4'b0011;
                        2'b01:   ctrl.sel = 4'b0100;
                        2'b10:   ctrl.sel = 4'b1001;
                        default: ctrl.sel = 4'b1110;
                    endcase
                end
            end
            ctrl_pkg::MODE_RD_REG: begin
                if (is_w1 || is_w2) begin
                    ctrl.sel_ctl = 1'b1;
                    ctrl.stop    = 1'b1;
                    ctrl.sel     = is_w1 ? 4'b0001 : 4'b1011;
                end
            end
            ctrl_pkg::MODE_RD_MEM: begin
                if (is_w1) begin
                    ctrl.stop      = 1'b1;
                    ctrl.short_cyc = 1'b1;
                    ctrl.sel_ctl   = 1'b1;
                    if (!status.st0) begin
                        ctrl.sbus = 1'b1;    // address from switches
                        ctrl.lar  = 1'b1;
                    end else begin
                        ctrl.mbus  = 1'b1;
                        ctrl.arinc = 1'b1;
                    end
                end
            end
            ctrl_pkg::MODE_WR_MEM: begin
                if (is_w1) begin
                    ctrl.sbus      = 1'b1;
                    ctrl.stop      = 1'b1;
                    ctrl.short_cyc = 1'b1;
                    ctrl.sel_ctl   = 1'b1;
                    if (!status.st0) begin
                        ctrl.lar = 1'b1;
                    end else begin
                        ctrl.memw  = 1'b1;   // switch data into memory
                        ctrl.arinc = 1'b1;
                    end
                end
            end
            default: ctrl = '0;   // idle and undefined codes
        endcase
    end

endmodule

`default_nettype wire

/* design/panel_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module panel_regs (
    input  wire                    t3,
    input  wire                    rst_n,
    input  ctrl_pkg::apb_req_t     apb_req,
    output ctrl_pkg::apb_rsp_t     apb_rsp,
    input  ctrl_pkg::seq_status_t  status,
    output ctrl_pkg::panel_mode_t  mode,
    output logic                   restart
);

    logic                   setup_phase;
    logic                   access_phase;
    logic                   hit_mode;
    logic                   hit_status;
    logic                   bad_access;
    logic [`APB_DATA_W-1:0] rd_data;
    logic [`APB_DATA_W-1:0] rdata_q;
    logic                   err_q;
    ctrl_pkg::panel_mode_t  mode_q;

    assign setup_phase  = apb_req.psel & ~apb_req.penable;
    assign access_phase = apb_req.psel & apb_req.penable;
    assign hit_mode     = (apb_req.paddr == `REG_MODE_OFS);
    assign hit_status   = (apb_req.paddr == `REG_STATUS_OFS);
    assign bad_access   = ~(hit_mode | hit_status) | (apb_req.pwrite & hit_status);

    // a MODE write also restarts the beat sequence
    assign restart = access_phase & apb_req.pwrite & hit_mode;

    always_comb begin
        rd_data = '0;
        if (hit_mode) begin
            rd_data[`CTRL_MODE_W-1:0] = mode_q;
        end else if (hit_status) begin
            rd_data[$bits(ctrl_pkg::seq_status_t)-1:0] = status;
        end
    end

    always_ff @(posedge t3) begin
        if (!rst_n) begin
            mode_q <= ctrl_pkg::panel_mode_t'(`MODE_RESET_CODE);
        end else if (restart) begin
            mode_q <= ctrl_pkg::panel_mode_t'(apb_req.pwdata[`CTRL_MODE_W-1:0]);
        end
    end

    // response is sampled in setup and presented during the access cycle
    always_ff @(posedge t3) begin
        if (!rst_n) begin
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else if (setup_phase) begin
            rdata_q <= apb_req.pwrite ? '0 : rd_data;
            err_q   <= bad_access;
        end else begin
            rdata_q <= '0;
            err_q   <= 1'b0;
        end
    end

    assign apb_rsp = '{prdata: rdata_q, pready: 1'b1, pslverr: err_q};  // no wait states
    assign mode    = mode_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_control_unit -o tb_control_unit

out=$(./obj_dir/tb_control_unit)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi
